/* Makefile */
# Verilator build and run of the reservation station testbench

VERILATOR ?= verilator
TOP       ?= tb_rs_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= TEST RESULT: FAIL
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail message"
	@echo "  build  compile only"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+include
design/rs_pkg.sv
design/rs_ifc.sv
design/dispatch_router.sv
design/rs_bank.sv
design/issue_stage.sv
design/rs_top.sv
test/tb_rs_top.sv

/* design/dispatch_router.sv */
`default_nettype none

`include "rs_defs.svh"

module dispatch_router
    import rs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatch_valid,
    input  rs_sel_t               dispatch_class,
    input  ptag_t                 ps1,
    input  ptag_t                 ps2,
    input  logic                  ps1_ready,
    input  logic                  ps2_ready,
    input  ptag_t                 pd,
    input  areg_t                 rd,
    input  rob_idx_t              rob,
    input  uop_info_t             uop,
    input  logic [`CDB_PORTS-1:0] cdb_valid,
    input  ptag_t                 cdb_tag [`CDB_PORTS],
    rs_dispatch_if.src            disp [`RS_CLASSES]
);

    logic ps1_hit;
    logic ps2_hit;

    // bypass, a result broadcast this cycle counts as ready at dispatch
    always_comb
    begin
        ps1_hit = 1'b0;
        ps2_hit = 1'b0;
        for (int p = 0; p < `CDB_PORTS; p++)
        begin
            if (cdb_valid[p] && cdb_tag[p] == ps1)
                ps1_hit = 1'b1;
            if (cdb_valid[p] && cdb_tag[p] == ps2)
                ps2_hit = 1'b1;
        end
    end

    for (genvar c = 0; c < `RS_CLASSES; c++)
    begin : g_class
        // one-hot, classes past the last bank select nothing
        assign disp[c].valid   = dispatch_valid && (dispatch_class == rs_sel_t'(c));
        assign disp[c].ps1     = ps1;
        assign disp[c].ps2     = ps2;
        assign disp[c].ps1_rdy = ps1_ready | ps1_hit;
        assign disp[c].ps2_rdy = ps2_ready | ps2_hit;
        assign disp[c].pd      = pd;
        assign disp[c].rd      = rd;
        assign disp[c].rob     = rob;
        assign disp[c].uop     = uop;
    end

    // a bad class would silently lose the micro-op
    a_class_range : assert property (
        @(posedge clk) disable iff (rst)
        dispatch_valid |-> dispatch_class < rs_sel_t'(`RS_CLASSES)
    );

endmodule

`default_nettype wire

/* design/issue_stage.sv */
`default_nettype none

`include "rs_defs.svh"

module issue_stage
    import rs_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    rs_issue_if.stage              iss [`RS_CLASSES],
    input  logic [`RS_CLASSES-1:0] fu_busy,
    output logic [`RS_CLASSES-1:0] issue_valid,
    output ptag_t                  issue_ps1 [`RS_CLASSES],
    output ptag_t                  issue_ps2 [`RS_CLASSES],
    output ptag_t                  issue_pd  [`RS_CLASSES],
    output areg_t                  issue_rd  [`RS_CLASSES],
    output rob_idx_t               issue_rob [`RS_CLASSES],
    output uop_info_t              issue_uop [`RS_CLASSES]
);

    logic [`RS_CLASSES-1:0] take;
    logic [`RS_CLASSES-1:0] pick_valid;

    // register can move when empty or when its unit is accepting
    assign take = ~issue_valid | ~fu_busy;

    always_ff @(posedge clk)
    begin
        if (rst)
            issue_valid <= '0;
        else
            issue_valid <= (take & pick_valid) | (~take & issue_valid);
    end

    for (genvar c = 0; c < `RS_CLASSES; c++)
    begin : g_class
        assign iss[c].take   = take[c];
        assign pick_valid[c] = iss[c].valid;

        always_ff @(posedge clk)
        begin
            if (take[c] && iss[c].valid)
            begin
                issue_ps1[c] <= iss[c].ps1;
                issue_ps2[c] <= iss[c].ps2;
                issue_pd[c]  <= iss[c].pd;
                issue_rd[c]  <= iss[c].rd;
                issue_rob[c] <= iss[c].rob;
                issue_uop[c] <= iss[c].uop;
            end
        end

        // unit stalled, so the held micro-op must not change under it
        a_hold_stable : assert property (
            @(posedge clk) disable iff (rst)
            (issue_valid[c] && fu_busy[c]) |=>
                issue_valid[c] && $stable(issue_ps1[c]) && $stable(issue_ps2[c])
                && $stable(issue_pd[c]) && $stable(issue_rd[c])
                && $stable(issue_rob[c]) && $stable(issue_uop[c])
        );
    end

endmodule

`default_nettype wire

/* design/rs_bank.sv */
`default_nettype none

`include "rs_defs.svh"

module rs_bank
    import rs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    rs_dispatch_if.dst            disp,
    input  logic [`CDB_PORTS-1:0] cdb_valid,
    input  ptag_t                 cdb_tag [`CDB_PORTS],
    rs_issue_if.bank              iss,
    output logic                  full
);

    localparam int IDX_W = $clog2(`RS_DEPTH);

    // entry control
    logic [`RS_DEPTH-1:0] busy;
    logic [`RS_DEPTH-1:0] rdy1;
    logic [`RS_DEPTH-1:0] rdy2;

    // entry payload
    ptag_t     ps1_q [`RS_DEPTH];
    ptag_t     ps2_q [`RS_DEPTH];
    ptag_t     pd_q  [`RS_DEPTH];
    areg_t     rd_q  [`RS_DEPTH];
    rob_idx_t  rob_q [`RS_DEPTH];
    uop_info_t uop_q [`RS_DEPTH];

    logic [`RS_DEPTH-1:0] wake1;
    logic [`RS_DEPTH-1:0] wake2;
    logic [`RS_DEPTH-1:0] ready_vec;
    logic [IDX_W-1:0]     free_idx;
    logic [IDX_W-1:0]     pick_idx;
    logic                 wr_en;
    logic                 free_en;

    assign full      = &busy;
    assign wr_en     = disp.valid && !full;   // dropped when full
    assign ready_vec = busy & rdy1 & rdy2;
    assign free_en   = iss.valid && iss.take;

    // lowest free slot and lowest ready entry, scanning down so index 0 wins
    always_comb
    begin
        free_idx = '0;
        pick_idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--)
        begin
            if (!busy[i])
                free_idx = IDX_W'(i);
            if (ready_vec[i])
                pick_idx = IDX_W'(i);
        end
    end

    // tag match against every broadcast bus
    always_comb
    begin
        wake1 = '0;
        wake2 = '0;
        for (int i = 0; i < `RS_DEPTH; i++)
        begin
            for (int p = 0; p < `CDB_PORTS; p++)
            begin
                if (cdb_valid[p] && cdb_tag[p] == ps1_q[i])
                    wake1[i] = 1'b1;
                if (cdb_valid[p] && cdb_tag[p] == ps2_q[i])
                    wake2[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
        end
        else
        begin
            rdy1 <= rdy1 | (wake1 & busy);
            rdy2 <= rdy2 | (wake2 & busy);
            if (free_en)
                busy[pick_idx] <= 1'b0;
            if (wr_en)
            begin
                busy[free_idx] <= 1'b1;
                rdy1[free_idx] <= disp.ps1_rdy;   // bypass already folded in
                rdy2[free_idx] <= disp.ps2_rdy;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            ps1_q[free_idx] <= disp.ps1;
            ps2_q[free_idx] <= disp.ps2;
            pd_q[free_idx]  <= disp.pd;
            rd_q[free_idx]  <= disp.rd;
            rob_q[free_idx] <= disp.rob;
            uop_q[free_idx] <= disp.uop;
        end
    end

    assign iss.valid = |ready_vec;
    assign iss.ps1   = ps1_q[pick_idx];
    assign iss.ps2   = ps2_q[pick_idx];
    assign iss.pd    = pd_q[pick_idx];
    assign iss.rd    = rd_q[pick_idx];
    assign iss.rob   = rob_q[pick_idx];
    assign iss.uop   = uop_q[pick_idx];

    a_write_free_slot : assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !busy[free_idx]
    );

    // the issue side must never free the slot dispatch is filling
    a_no_write_and_free : assert property (
        @(posedge clk) disable iff (rst)
        (wr_en && free_en) |-> free_idx != pick_idx
    );

endmodule

`default_nettype wire

/* design/rs_ifc.sv */
`default_nettype none

// one renamed micro-op headed for a single bank, valid for one cycle
interface rs_dispatch_if
    import rs_pkg::*;
();
    logic      valid;
    ptag_t     ps1;
    ptag_t     ps2;
    logic      ps1_rdy;   // already includes the same-cycle bypass
    logic      ps2_rdy;
    ptag_t     pd;
    areg_t     rd;
    rob_idx_t  rob;
    uop_info_t uop;

    modport src (output valid, ps1, ps2, ps1_rdy, ps2_rdy, pd, rd, rob, uop);
    modport dst (input  valid, ps1, ps2, ps1_rdy, ps2_rdy, pd, rd, rob, uop);
endinterface

// bank pick toward the issue register
interface rs_issue_if
    import rs_pkg::*;
();
    logic      valid;   // bank has a ready entry
    logic      take;    // issue register accepts this cycle
    ptag_t     ps1;
    ptag_t     ps2;
    ptag_t     pd;
    areg_t     rd;
    rob_idx_t  rob;
    uop_info_t uop;

    modport bank
    (
        output valid, ps1, ps2, pd, rd, rob, uop,
        input  take
    );
    modport stage
    (
        input  valid, ps1, ps2, pd, rd, rob, uop,
        output take
    );
endinterface

`default_nettype wire

/* design/rs_pkg.sv */
`default_nettype none

`include "rs_defs.svh"

package rs_pkg;

    typedef logic [`PTAG_W-1:0] ptag_t;     // physical register tag
    typedef logic [`AREG_W-1:0] areg_t;     // architectural dest
    typedef logic [`ROB_W-1:0]  rob_idx_t;
    typedef logic [`UOP_W-1:0]  uop_info_t; // decode info, not interpreted here

    // 0 add, 1 mul, 2 div, 3 branch, 4 mem
    typedef logic [2:0] rs_sel_t;

endpackage

`default_nettype wire

/* design/rs_top.sv */
`default_nettype none

`include "rs_defs.svh"

module rs_top
    import rs_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // dispatch
    input  logic                   dispatch_valid,
    input  rs_sel_t                dispatch_class,
    input  ptag_t                  ps1,
    input  ptag_t                  ps2,
    input  logic                   ps1_ready,
    input  logic                   ps2_ready,
    input  ptag_t                  pd,
    input  areg_t                  rd,
    input  rob_idx_t               rob,
    input  uop_info_t              uop,

    // result broadcast
    input  logic [`CDB_PORTS-1:0]  cdb_valid,
    input  ptag_t                  cdb_tag [`CDB_PORTS],

    // functional units
    input  logic [`RS_CLASSES-1:0] fu_busy,
    output logic [`RS_CLASSES-1:0] issue_valid,
    output ptag_t                  issue_ps1 [`RS_CLASSES],
    output ptag_t                  issue_ps2 [`RS_CLASSES],
    output ptag_t                  issue_pd  [`RS_CLASSES],
    output areg_t                  issue_rd  [`RS_CLASSES],
    output rob_idx_t               issue_rob [`RS_CLASSES],
    output uop_info_t              issue_uop [`RS_CLASSES],

    output logic [`RS_CLASSES-1:0] rs_full
);

    rs_dispatch_if disp_if [`RS_CLASSES] ();
    rs_issue_if    iss_if  [`RS_CLASSES] ();

    dispatch_router u_router
    (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_class (dispatch_class),
        .ps1            (ps1),
        .ps2            (ps2),
        .ps1_ready      (ps1_ready),
        .ps2_ready      (ps2_ready),
        .pd             (pd),
        .rd             (rd),
        .rob            (rob),
        .uop            (uop),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .disp           (disp_if)
    );

    // one bank per class, add mul div branch mem
    for (genvar c = 0; c < `RS_CLASSES; c++)
    begin : g_bank
        rs_bank u_bank
        (
            .clk       (clk),
            .rst       (rst),
            .disp      (disp_if[c]),
            .cdb_valid (cdb_valid),
            .cdb_tag   (cdb_tag),
            .iss       (iss_if[c]),
            .full      (rs_full[c])
        );
    end

    issue_stage u_issue
    (
        .clk         (clk),
        .rst         (rst),
        .iss         (iss_if),
        .fu_busy     (fu_busy),
        .issue_valid (issue_valid),
        .issue_ps1   (issue_ps1),
        .issue_ps2   (issue_ps2),
        .issue_pd    (issue_pd),
        .issue_rd    (issue_rd),
        .issue_rob   (issue_rob),
        .issue_uop   (issue_uop)
    );

endmodule

`default_nettype wire

/* include/rs_defs.svh */
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

// station organization
`define RS_CLASSES 5   // add, mul, div, branch, mem
`define RS_DEPTH   4   // entries per bank

// field widths
`define PTAG_W 6
`define AREG_W 5
`define ROB_W  6
`define UOP_W  16

// result broadcast buses
`define CDB_PORTS 5

`endif

/* test/tb_rs_top.sv */
`default_nettype none

`include "rs_defs.svh"

module tb_rs_top
    import rs_pkg::*;
();

    localparam int DIRECTED_CYCLES = 50;    // reset plus the directed sequences
    localparam int RANDOM_CYCLES   = 400;
    localparam int DRAIN_CYCLES    = 40;    // tag sweep, then up to five issues per class
    localparam int MAX_CYCLES      = DIRECTED_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES + 50;

    typedef struct packed {
        ptag_t     ps1;
        ptag_t     ps2;
        ptag_t     pd;
        areg_t     rd;
        rob_idx_t  rob;
        uop_info_t uop;
    } uop_rec_t;

    logic                   clk;
    logic                   rst;
    logic                   dispatch_valid;
    rs_sel_t                dispatch_class;
    ptag_t                  ps1;
    ptag_t                  ps2;
    logic                   ps1_ready;
    logic                   ps2_ready;
    ptag_t                  pd;
    areg_t                  rd;
    rob_idx_t               rob;
    uop_info_t              uop;
    logic [`CDB_PORTS-1:0]  cdb_valid;
    ptag_t                  cdb_tag [`CDB_PORTS];
    logic [`RS_CLASSES-1:0] fu_busy;
    logic [`RS_CLASSES-1:0] issue_valid;
    ptag_t                  issue_ps1 [`RS_CLASSES];
    ptag_t                  issue_ps2 [`RS_CLASSES];
    ptag_t                  issue_pd  [`RS_CLASSES];
    areg_t                  issue_rd  [`RS_CLASSES];
    rob_idx_t               issue_rob [`RS_CLASSES];
    uop_info_t              issue_uop [`RS_CLASSES];
    logic [`RS_CLASSES-1:0] rs_full;

    // reference state, one bank of slots and one issue register per class
    logic     m_busy [`RS_CLASSES][`RS_DEPTH];
    logic     m_rdy1 [`RS_CLASSES][`RS_DEPTH];
    logic     m_rdy2 [`RS_CLASSES][`RS_DEPTH];
    uop_rec_t m_slot [`RS_CLASSES][`RS_DEPTH];
    logic     m_iv   [`RS_CLASSES];
    uop_rec_t m_iss  [`RS_CLASSES];

    int cycles          = 0;
    int check_errors    = 0;
    int directed_errors = 0;
    int other_errors    = 0;
    int accepted        = 0;   // micro-ops the model wrote into a bank
    int consumed        = 0;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    rs_top u_rs_top (.*);

    function automatic logic tag_broadcast(input ptag_t tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `CDB_PORTS; p++)
            if (cdb_valid[p] && cdb_tag[p] == tag)
                hit = 1'b1;
        return hit;
    endfunction

    function automatic logic model_full(input int c);
        logic all_busy;
        all_busy = 1'b1;
        for (int s = 0; s < `RS_DEPTH; s++)
            if (!m_busy[c][s])
                all_busy = 1'b0;
        return all_busy;
    endfunction

    function automatic uop_rec_t issue_rec(input int c);
        return {issue_ps1[c], issue_ps2[c], issue_pd[c], issue_rd[c], issue_rob[c], issue_uop[c]};
    endfunction

    function automatic void model_reset();
        for (int c = 0; c < `RS_CLASSES; c++)
        begin
            m_iv[c] = 1'b0;
            for (int s = 0; s < `RS_DEPTH; s++)
                m_busy[c][s] = 1'b0;
        end
    endfunction

    // one clock edge of the stations, from the inputs held during the cycle
    function automatic void model_step();
        int   pick;
        int   slot;
        logic take;
        for (int c = 0; c < `RS_CLASSES; c++)
        begin
            pick = -1;
            slot = -1;
            for (int s = 0; s < `RS_DEPTH; s++)
            begin
                if (slot < 0 && !m_busy[c][s])
                    slot = s;
                if (pick < 0 && m_busy[c][s] && m_rdy1[c][s] && m_rdy2[c][s])
                    pick = s;
            end
            if (m_iv[c] && !fu_busy[c])
                consumed++;
            take = !m_iv[c] || !fu_busy[c];   // busy unit with a full register holds
            if (take)
            begin
                m_iv[c] = (pick >= 0);
                if (pick >= 0)
                    m_iss[c] = m_slot[c][pick];
            end
            for (int s = 0; s < `RS_DEPTH; s++)
            begin
                if (m_busy[c][s] && tag_broadcast(m_slot[c][s].ps1))
                    m_rdy1[c][s] = 1'b1;
                if (m_busy[c][s] && tag_broadcast(m_slot[c][s].ps2))
                    m_rdy2[c][s] = 1'b1;
            end
            if (take && pick >= 0)
                m_busy[c][pick] = 1'b0;
            if (dispatch_valid && int'(dispatch_class) == c && slot >= 0)
            begin
                m_busy[c][slot] = 1'b1;
                m_rdy1[c][slot] = ps1_ready || tag_broadcast(ps1);   // same-cycle bypass
                m_rdy2[c][slot] = ps2_ready || tag_broadcast(ps2);
                m_slot[c][slot] = {ps1, ps2, pd, rd, rob, uop};
                accepted++;
            end
        end
    endfunction

    always @(posedge clk)
    begin
        if (rst)
            model_reset();
        else
            model_step();
    end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk)
    begin
        if (!rst)
        begin
            for (int c = 0; c < `RS_CLASSES; c++)
            begin
                if (issue_valid[c] !== m_iv[c])
                begin
                    check_errors++;
                    $display("FAIL @%0t: class %0d issue_valid %b, model %b",
                             $time, c, issue_valid[c], m_iv[c]);
                end
                else if (m_iv[c] && issue_rec(c) !== m_iss[c])
                begin
                    check_errors++;
                    $display("FAIL @%0t: class %0d issued %h, model %h",
                             $time, c, issue_rec(c), m_iss[c]);
                end
                if (rs_full[c] !== model_full(c))
                begin
                    check_errors++;
                    $display("FAIL @%0t: class %0d rs_full %b, model %b",
                             $time, c, rs_full[c], model_full(c));
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles, micro-ops were still in flight", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic expect_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            directed_errors++;
            $display("FAIL @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic quiet_inputs();
        dispatch_valid = 1'b0;
        cdb_valid      = '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge clk);
            quiet_inputs();
        end
    endtask

    // bc_tag below zero means no broadcast alongside the dispatch
    task automatic send_uop(input int cls, input logic r1, input logic r2,
                            input int t1, input int t2, input int bc_tag);
        @(negedge clk);
        quiet_inputs();
        dispatch_valid = 1'b1;
        dispatch_class = rs_sel_t'(cls);
        ps1            = ptag_t'(t1);
        ps2            = ptag_t'(t2);
        ps1_ready      = r1;
        ps2_ready      = r2;
        pd             = ptag_t'($urandom);
        rd             = areg_t'($urandom);
        rob            = rob_idx_t'($urandom);
        uop            = uop_info_t'($urandom);
        if (bc_tag >= 0)
        begin
            cdb_valid[0] = 1'b1;
            cdb_tag[0]   = ptag_t'(bc_tag);
        end
    endtask

    task automatic broadcast(input int base, input int n);
        @(negedge clk);
        quiet_inputs();
        for (int p = 0; p < n; p++)
        begin
            cdb_valid[p] = 1'b1;
            cdb_tag[p]   = ptag_t'(base + p);
        end
    endtask

    task automatic random_traffic(input int n);
        repeat (n)
        begin
            @(negedge clk);
            dispatch_valid = 1'($urandom);
            dispatch_class = rs_sel_t'($urandom_range(`RS_CLASSES - 1));
            ps1            = ptag_t'(40 + $urandom_range(15));   // small pool, frequent wakeups
            ps2            = ptag_t'(40 + $urandom_range(15));
            ps1_ready      = ($urandom_range(3) == 0);
            ps2_ready      = ($urandom_range(3) == 0);
            pd             = ptag_t'($urandom);
            rd             = areg_t'($urandom);
            rob            = rob_idx_t'($urandom);
            uop            = uop_info_t'($urandom);
            for (int p = 0; p < `CDB_PORTS; p++)
            begin
                cdb_valid[p] = ($urandom_range(2) == 0);
                cdb_tag[p]   = ptag_t'(40 + $urandom_range(15));
            end
            for (int c = 0; c < `RS_CLASSES; c++)
                fu_busy[c] = ($urandom_range(2) == 0);
        end
    endtask

    // sweep every tag over the buses until the model has nothing left
    task automatic drain();
        int base;
        base = 0;
        while (accepted != consumed)
        begin
            @(negedge clk);
            quiet_inputs();
            fu_busy = '0;
            for (int p = 0; p < `CDB_PORTS; p++)
            begin
                cdb_valid[p] = 1'b1;
                cdb_tag[p]   = ptag_t'(base + p);
            end
            base = (base + `CDB_PORTS) % (1 << `PTAG_W);
        end
    endtask

    initial
    begin
        void'($urandom(68));
        rst = 1'b1;
        quiet_inputs();
        dispatch_class = '0;
        ps1            = '0;
        ps2            = '0;
        ps1_ready      = 1'b0;
        ps2_ready      = 1'b0;
        pd             = '0;
        rd             = '0;
        rob            = '0;
        uop            = '0;
        fu_busy        = '0;
        for (int p = 0; p < `CDB_PORTS; p++)
            cdb_tag[p] = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        for (int c = 0; c < `RS_CLASSES; c++)
        begin
            expect_bit(issue_valid[c], 1'b0, $sformatf("issue_valid[%0d] after reset", c));
            expect_bit(rs_full[c], 1'b0, $sformatf("rs_full[%0d] after reset", c));
        end

        // both operands ready, two cycles to the issue register
        for (int c = 0; c < `RS_CLASSES; c++)
        begin
            send_uop(c, 1'b1, 1'b1, 1, 2, -1);
            idle_cycles(1);
            expect_bit(issue_valid[c], 1'b0, $sformatf("issue_valid[%0d] at t+1", c));
            idle_cycles(1);
            expect_bit(issue_valid[c], 1'b1, $sformatf("issue_valid[%0d] at t+2", c));
            expect_bit(issue_rob[c] === rob && issue_uop[c] === uop, 1'b1,
                       $sformatf("class %0d rob and uop match", c));
        end

        send_uop(1, 1'b1, 1'b0, 3, 20, -1);
        idle_cycles(3);
        expect_bit(issue_valid[1], 1'b0, "issue_valid[1] waiting on tag 20");
        broadcast(20, 1);
        idle_cycles(1);
        expect_bit(issue_valid[1], 1'b0, "issue_valid[1] one cycle after wakeup");
        idle_cycles(1);
        expect_bit(issue_valid[1], 1'b1, "issue_valid[1] two cycles after wakeup");
        send_uop(2, 1'b1, 1'b0, 3, 21, 21);
        idle_cycles(2);
        expect_bit(issue_valid[2], 1'b1, "issue_valid[2] through bypass");

        // fill the branch bank, fifth one is dropped, model checks the issue order
        for (int i = 0; i < `RS_DEPTH; i++)
            send_uop(3, 1'b0, 1'b1, 30 + i, 5, -1);
        idle_cycles(1);
        expect_bit(rs_full[3], 1'b1, "rs_full[3] after four waiting dispatches");
        send_uop(3, 1'b1, 1'b1, 7, 8, -1);
        broadcast(30, 4);
        idle_cycles(8);

        random_traffic(RANDOM_CYCLES);
        drain();
        idle_cycles(4);
        if (issue_valid !== '0 || rs_full !== '0)
        begin
            other_errors++;
            $display("stations still hold micro-ops after the drain");
        end

        $display("errors: %0d compare, %0d directed, %0d other (%0d accepted, %0d consumed)",
                 check_errors, directed_errors, other_errors, accepted, consumed);
        if (check_errors + directed_errors + other_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
